//--- logic/rv32i_isa_pkg.sv
/* RV32I instruction set definitions
   Formats, opcodes, function codes and the decoded control word */
package rv32i_isa_pkg;

localparam int XLEN       = 32;
localparam int REG_ADDR_W = 5;

typedef logic [XLEN-1:0] word_t;

// ==============================
// Opcodes and function codes
// ==============================
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_FENCE  = 7'b0001111;
localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

// ALU group
localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

// Branch group
localparam logic [2:0] F3_BEQ  = 3'b000;
localparam logic [2:0] F3_BNE  = 3'b001;
localparam logic [2:0] F3_BLT  = 3'b100;
localparam logic [2:0] F3_BGE  = 3'b101;
localparam logic [2:0] F3_BLTU = 3'b110;
localparam logic [2:0] F3_BGEU = 3'b111;

// Load and store group, low two bits give the size
localparam logic [2:0] F3_BYTE  = 3'b000;
localparam logic [2:0] F3_HALF  = 3'b001;
localparam logic [2:0] F3_WORD  = 3'b010;
localparam logic [2:0] F3_BYTEU = 3'b100;
localparam logic [2:0] F3_HALFU = 3'b101;

localparam logic [1:0] MEM_BYTE = 2'd0;
localparam logic [1:0] MEM_HALF = 2'd1;

localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

// ==============================
// Instruction formats
// ==============================
typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} i_fmt_t;

typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
} s_fmt_t;

typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
} b_fmt_t;

typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} u_fmt_t;

typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
} j_fmt_t;

// One fetched word, read through the view its opcode selects
typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
} instr_t;

// ==============================
// Decoded control
// ==============================
typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
} alu_op_t;

typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_LINK,
    WB_LOAD
} wb_sel_t;

typedef struct packed {
    alu_op_t    alu_op;
    logic       use_imm;     // Immediate as second operand
    logic       pc_operand;  // pc as first operand, AUIPC
    wb_sel_t    wb_sel;
    logic       reg_write;
    logic       is_load;
    logic       is_store;
    logic [1:0] mem_size;
    logic       mem_unsigned;
    logic       is_branch;
    logic [2:0] branch_f3;
    logic       is_jal;
    logic       is_jalr;
    logic       halt;
} ctrl_t;

endpackage

//--- logic/core_bus_pkg.sv
/* Core bus definitions
   Data bus request format and the reset vector */
package core_bus_pkg;

localparam rv32i_isa_pkg::word_t RESET_VECTOR = '0;
localparam int                   STRB_W       = 4;

typedef logic [STRB_W-1:0] strb_t;

// Memory answers in the same cycle, no handshake
typedef struct packed {
    rv32i_isa_pkg::word_t addr;   // Word address
    rv32i_isa_pkg::word_t wdata;  // Store data already in its lanes
    strb_t                wstrb;  // Any bit set means write
    logic                 read;
} dbus_req_t;

endpackage

//--- logic/pc_unit.sv
/* Program counter
   Next address selection and the sticky halt state */
`timescale 1ns/10ps
module pc_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32i_isa_pkg::ctrl_t  ctrl,
    input  logic                  branch_taken,
    input  rv32i_isa_pkg::word_t  jump_target,
    output rv32i_isa_pkg::word_t  pc,
    output logic                  halted
);

rv32i_isa_pkg::word_t next_pc;
logic                 redirect;

assign redirect = ctrl.is_jal | ctrl.is_jalr | branch_taken;

always_comb begin
    if (halted || ctrl.halt) begin
        next_pc = pc;                   // Park on the halting instruction
    end else if (redirect) begin
        next_pc = jump_target;
    end else begin
        next_pc = pc + 32'd4;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        pc     <= core_bus_pkg::RESET_VECTOR;
        halted <= 1'b0;
    end else begin
        pc <= next_pc;
        if (ctrl.halt) begin
            halted <= 1'b1;             // Only reset clears it
        end
    end
end

endmodule

//--- logic/instr_decoder.sv
/* Instruction decoder
   Register indices, sign-extended immediate and the control word */
`timescale 1ns/10ps
module instr_decoder (
    input  rv32i_isa_pkg::instr_t                 instr,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rs1,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rs2,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rd,
    output rv32i_isa_pkg::word_t                  imm,
    output rv32i_isa_pkg::ctrl_t                  ctrl
);

rv32i_isa_pkg::word_t   i_imm, s_imm, b_imm, u_imm, j_imm;
rv32i_isa_pkg::alu_op_t alu_sel;
logic                   alu_legal;
logic                   legal;
logic                   is_op_imm;
logic                   alt;
logic [2:0]             f3;
logic [6:0]             f7;

assign rs1       = instr.r.rs1;
assign rs2       = instr.r.rs2;
assign rd        = instr.r.rd;
assign f3        = instr.r.funct3;
assign f7        = instr.r.funct7;
assign is_op_imm = (instr.r.opcode == rv32i_isa_pkg::OPC_OP_IMM);
assign alt       = (f7 == rv32i_isa_pkg::F7_ALT);

// ==============================
// Immediates
// ==============================
assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
assign s_imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
assign b_imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
assign u_imm = {instr.u.imm31_12, 12'b0};
assign j_imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};

// ALU operation, shared by OP and OP_IMM
always_comb begin
    alu_sel   = rv32i_isa_pkg::ALU_ADD;
    alu_legal = is_op_imm || f7 == rv32i_isa_pkg::F7_BASE
             || (alt && (f3 == rv32i_isa_pkg::F3_ADD || f3 == rv32i_isa_pkg::F3_SR));
    case (f3)
        rv32i_isa_pkg::F3_ADD: begin
            if (alt && !is_op_imm) begin
                alu_sel = rv32i_isa_pkg::ALU_SUB;
            end
        end
        rv32i_isa_pkg::F3_SLL: begin
            alu_sel = rv32i_isa_pkg::ALU_SLL;
            if (is_op_imm) begin
                alu_legal = (f7 == rv32i_isa_pkg::F7_BASE);  // Five-bit shamt only
            end
        end
        rv32i_isa_pkg::F3_SLT:  alu_sel = rv32i_isa_pkg::ALU_SLT;
        rv32i_isa_pkg::F3_SLTU: alu_sel = rv32i_isa_pkg::ALU_SLTU;
        rv32i_isa_pkg::F3_XOR:  alu_sel = rv32i_isa_pkg::ALU_XOR;
        rv32i_isa_pkg::F3_SR: begin
            alu_sel = alt ? rv32i_isa_pkg::ALU_SRA : rv32i_isa_pkg::ALU_SRL;
            if (is_op_imm) begin
                alu_legal = alt || f7 == rv32i_isa_pkg::F7_BASE;
            end
        end
        rv32i_isa_pkg::F3_OR:   alu_sel = rv32i_isa_pkg::ALU_OR;
        rv32i_isa_pkg::F3_AND:  alu_sel = rv32i_isa_pkg::ALU_AND;
    endcase
end

// ==============================
// Main decode
// ==============================
always_comb begin
    ctrl              = '0;
    ctrl.mem_size     = f3[1:0];
    ctrl.mem_unsigned = f3[2];
    ctrl.branch_f3    = instr.b.funct3;
    imm               = '0;
    legal             = 1'b1;
    case (instr.r.opcode)
        rv32i_isa_pkg::OPC_LUI: begin
            imm            = u_imm;
            ctrl.wb_sel    = rv32i_isa_pkg::WB_IMM;
            ctrl.reg_write = 1'b1;
        end
        rv32i_isa_pkg::OPC_AUIPC: begin
            imm             = u_imm;
            ctrl.pc_operand = 1'b1;
            ctrl.use_imm    = 1'b1;
            ctrl.reg_write  = 1'b1;
        end
        rv32i_isa_pkg::OPC_JAL: begin
            imm            = j_imm;
            ctrl.is_jal    = 1'b1;
            ctrl.wb_sel    = rv32i_isa_pkg::WB_LINK;
            ctrl.reg_write = 1'b1;
        end
        rv32i_isa_pkg::OPC_JALR: begin
            imm            = i_imm;
            ctrl.is_jalr   = 1'b1;
            ctrl.wb_sel    = rv32i_isa_pkg::WB_LINK;
            ctrl.reg_write = 1'b1;
            legal          = (instr.i.funct3 == 3'b000);
        end
        rv32i_isa_pkg::OPC_BRANCH: begin
            imm            = b_imm;
            ctrl.is_branch = 1'b1;
            legal          = instr.b.funct3 inside {rv32i_isa_pkg::F3_BEQ,
                rv32i_isa_pkg::F3_BNE, rv32i_isa_pkg::F3_BLT, rv32i_isa_pkg::F3_BGE,
                rv32i_isa_pkg::F3_BLTU, rv32i_isa_pkg::F3_BGEU};
        end
        rv32i_isa_pkg::OPC_LOAD: begin
            imm            = i_imm;
            ctrl.use_imm   = 1'b1;
            ctrl.is_load   = 1'b1;
            ctrl.wb_sel    = rv32i_isa_pkg::WB_LOAD;
            ctrl.reg_write = 1'b1;
            legal          = f3 inside {rv32i_isa_pkg::F3_BYTE, rv32i_isa_pkg::F3_HALF,
                rv32i_isa_pkg::F3_WORD, rv32i_isa_pkg::F3_BYTEU, rv32i_isa_pkg::F3_HALFU};
        end
        rv32i_isa_pkg::OPC_STORE: begin
            imm           = s_imm;
            ctrl.use_imm  = 1'b1;
            ctrl.is_store = 1'b1;
            legal         = instr.s.funct3 inside {rv32i_isa_pkg::F3_BYTE,
                rv32i_isa_pkg::F3_HALF, rv32i_isa_pkg::F3_WORD};
        end
        rv32i_isa_pkg::OPC_OP_IMM: begin
            imm            = i_imm;
            ctrl.use_imm   = 1'b1;
            ctrl.alu_op    = alu_sel;
            ctrl.reg_write = 1'b1;
            legal          = alu_legal;
        end
        rv32i_isa_pkg::OPC_OP: begin
            ctrl.alu_op    = alu_sel;
            ctrl.reg_write = 1'b1;
            legal          = alu_legal;
        end
        rv32i_isa_pkg::OPC_FENCE: ;  // No-op, memory is already in order
        rv32i_isa_pkg::OPC_SYSTEM: legal = 1'b0;  // ECALL, EBREAK, CSR stop the core
        default: legal = 1'b0;
    endcase

    // Stop the core with no side effects
    if (!legal) begin
        ctrl      = '0;
        ctrl.halt = 1'b1;
    end
end

endmodule

//--- logic/reg_file.sv
/* Integer register file
   Two asynchronous read ports, one write port, x0 reads as zero */
`timescale 1ns/10ps
module reg_file (
    input  logic                                  clk,
    input  logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rs1,
    input  logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rs2,
    input  logic [rv32i_isa_pkg::REG_ADDR_W-1:0]  rd,
    input  logic                                  we,
    input  rv32i_isa_pkg::word_t                  wd,
    output rv32i_isa_pkg::word_t                  rs1_data,
    output rv32i_isa_pkg::word_t                  rs2_data
);

rv32i_isa_pkg::word_t regs [0:(1 << rv32i_isa_pkg::REG_ADDR_W)-1];

always_ff @(posedge clk) begin
    if (we && rd != '0) begin
        regs[rd] <= wd;
    end
end

// x0 never written, so force it on read
assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/execute_unit.sv
/* Execute stage
   ALU, branch compare, jump target and link address */
`timescale 1ns/10ps
module execute_unit (
    input  rv32i_isa_pkg::ctrl_t  ctrl,
    input  rv32i_isa_pkg::word_t  pc,
    input  rv32i_isa_pkg::word_t  rs1_data,
    input  rv32i_isa_pkg::word_t  rs2_data,
    input  rv32i_isa_pkg::word_t  imm,
    output rv32i_isa_pkg::word_t  alu_result,
    output rv32i_isa_pkg::word_t  jump_target,
    output rv32i_isa_pkg::word_t  link,
    output logic                  branch_taken
);

rv32i_isa_pkg::word_t op_a, op_b;
rv32i_isa_pkg::word_t jalr_sum;
logic [4:0]           shamt;
logic                 eq, lt, ltu;
logic                 cond;

assign op_a  = ctrl.pc_operand ? pc : rs1_data;
assign op_b  = ctrl.use_imm ? imm : rs2_data;
assign shamt = op_b[4:0];

always_comb begin
    case (ctrl.alu_op)
        rv32i_isa_pkg::ALU_SUB:  alu_result = op_a - op_b;
        rv32i_isa_pkg::ALU_SLL:  alu_result = op_a << shamt;
        rv32i_isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
        rv32i_isa_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
        rv32i_isa_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
        rv32i_isa_pkg::ALU_SRL:  alu_result = op_a >> shamt;
        rv32i_isa_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
        rv32i_isa_pkg::ALU_OR:   alu_result = op_a | op_b;
        rv32i_isa_pkg::ALU_AND:  alu_result = op_a & op_b;
        default:                 alu_result = op_a + op_b;  // Also address and AUIPC
    endcase
end

// ==============================
// Branch and jump
// ==============================
assign eq  = (rs1_data == rs2_data);
assign lt  = ($signed(rs1_data) < $signed(rs2_data));
assign ltu = (rs1_data < rs2_data);

always_comb begin
    case (ctrl.branch_f3)
        rv32i_isa_pkg::F3_BEQ:  cond = eq;
        rv32i_isa_pkg::F3_BNE:  cond = !eq;
        rv32i_isa_pkg::F3_BLT:  cond = lt;
        rv32i_isa_pkg::F3_BGE:  cond = !lt;
        rv32i_isa_pkg::F3_BLTU: cond = ltu;
        rv32i_isa_pkg::F3_BGEU: cond = !ltu;
        default:                cond = 1'b0;
    endcase
end

assign branch_taken = ctrl.is_branch & cond;
assign jalr_sum     = rs1_data + imm;
assign jump_target  = ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;
assign link         = pc + 32'd4;  // Return address for JAL and JALR

endmodule

//--- logic/load_store_unit.sv
/* Load and store path
   Data bus request with byte strobes, load extension, writeback select */
`timescale 1ns/10ps
module load_store_unit (
    input  rv32i_isa_pkg::ctrl_t     ctrl,
    input  logic                     halted,
    input  rv32i_isa_pkg::word_t     addr,
    input  rv32i_isa_pkg::word_t     store_data,
    input  rv32i_isa_pkg::word_t     link,
    input  rv32i_isa_pkg::word_t     imm,
    output core_bus_pkg::dbus_req_t  dbus_req,
    input  rv32i_isa_pkg::word_t     dbus_rdata,
    output rv32i_isa_pkg::word_t     wb_data
);

core_bus_pkg::strb_t  size_strb;
rv32i_isa_pkg::word_t lane_data;
rv32i_isa_pkg::word_t load_data;
logic [4:0]           lane_shift;

assign lane_shift = {addr[1:0], 3'b000};  // Aligned access assumed

always_comb begin
    case (ctrl.mem_size)
        rv32i_isa_pkg::MEM_BYTE: size_strb = 4'b0001;
        rv32i_isa_pkg::MEM_HALF: size_strb = 4'b0011;
        default:                 size_strb = 4'b1111;
    endcase
end

assign dbus_req.addr  = {2'b00, addr[31:2]};
assign dbus_req.wdata = store_data << lane_shift;
assign dbus_req.wstrb = (ctrl.is_store && !halted) ? size_strb << addr[1:0] : '0;
assign dbus_req.read  = ctrl.is_load && !halted;

// Addressed lane moved down to bit 0
assign lane_data = dbus_rdata >> lane_shift;

always_comb begin
    case (ctrl.mem_size)
        rv32i_isa_pkg::MEM_BYTE:
            load_data = {{24{lane_data[7] & ~ctrl.mem_unsigned}}, lane_data[7:0]};
        rv32i_isa_pkg::MEM_HALF:
            load_data = {{16{lane_data[15] & ~ctrl.mem_unsigned}}, lane_data[15:0]};
        default:
            load_data = lane_data;
    endcase
end

always_comb begin
    case (ctrl.wb_sel)
        rv32i_isa_pkg::WB_IMM:  wb_data = imm;        // LUI
        rv32i_isa_pkg::WB_LINK: wb_data = link;
        rv32i_isa_pkg::WB_LOAD: wb_data = load_data;
        default:                wb_data = addr;       // ALU result
    endcase
end

endmodule

//--- logic/rv32i_core.sv
/* RV32I single-cycle core
   One instruction retired per clock, memories outside the core */
`timescale 1ns/10ps
module rv32i_core (
    input  logic                     clk,
    input  logic                     rst,
    output rv32i_isa_pkg::word_t     fetch_addr,
    input  rv32i_isa_pkg::word_t     fetch_data,
    output core_bus_pkg::dbus_req_t  dbus_req,
    input  rv32i_isa_pkg::word_t     dbus_rdata,
    output logic                     halted
);

rv32i_isa_pkg::instr_t               instr;
rv32i_isa_pkg::ctrl_t                ctrl;
logic [rv32i_isa_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
rv32i_isa_pkg::word_t                pc, imm;
rv32i_isa_pkg::word_t                rs1_data, rs2_data;
rv32i_isa_pkg::word_t                alu_result, jump_target, link;
rv32i_isa_pkg::word_t                wb_data;
logic                                branch_taken;
logic                                reg_we;

assign instr      = rv32i_isa_pkg::instr_t'(fetch_data);
assign fetch_addr = pc;
assign reg_we     = ctrl.reg_write & ~halted;  // Nothing retires while halted

// ==============================
// Units
// ==============================
pc_unit u_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .jump_target  (jump_target),
    .pc           (pc),
    .halted       (halted)
);

instr_decoder u_instr_decoder (
    .instr (instr),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .imm   (imm),
    .ctrl  (ctrl)
);

reg_file u_reg_file (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (reg_we),
    .wd       (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

execute_unit u_execute_unit (
    .ctrl         (ctrl),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .alu_result   (alu_result),
    .jump_target  (jump_target),
    .link         (link),
    .branch_taken (branch_taken)
);

load_store_unit u_load_store_unit (
    .ctrl       (ctrl),
    .halted     (halted),
    .addr       (alu_result),
    .store_data (rs2_data),
    .link       (link),
    .imm        (imm),
    .dbus_req   (dbus_req),
    .dbus_rdata (dbus_rdata),
    .wb_data    (wb_data)
);

endmodule

//--- test/tb_clock_gen.sv
/* Testbench clock and reset
   10 ns clock, reset held for 2 cycles at start and on each request */
`timescale 1ns/10ps
module tb_clock_gen (
    input  logic rst_req,
    output logic clk,
    output logic rst
);

logic [1:0] cnt;

initial begin
    clk = 1'b0;
    cnt = 2'd2;  // Power-on reset
end

always #5 clk = ~clk;

// Reset moves on the falling edge
always @(negedge clk) begin
    if (rst_req) begin
        cnt <= 2'd2;
    end else if (cnt != 2'd0) begin
        cnt <= cnt - 2'd1;
    end
end

assign rst = (cnt != 2'd0);

endmodule

//--- test/rv32i_core_tb.sv
/* RV32I core testbench
   Memory models, small program builder and store, reset and halt checks */
`timescale 1ns/10ps
module rv32i_core_tb;

logic                    clk, rst, rst_req, halted;
logic [31:0]             fetch_addr, fetch_data, dbus_rdata;
core_bus_pkg::dbus_req_t dbus_req;
logic [31:0]             imem [0:255];
logic [31:0]             dmem [0:255];
logic [31:0]             prog [$];
logic [31:0]             exp_data [$];
logic [3:0]              exp_strb [$];
logic [31:0]             seed, halt_pc, e_d;
logic [3:0]              e_s;
logic                    prev_rst, halt_due;
string                   cur_test;
int                      store_errs, ctrl_errs, cycles, cycle_limit;

tb_clock_gen u_clock_gen (.rst_req(rst_req), .clk(clk), .rst(rst));

rv32i_core dut (
    .clk        (clk),
    .rst        (rst),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .dbus_req   (dbus_req),
    .dbus_rdata (dbus_rdata),
    .halted     (halted)
);

// ==============================
// Memory models
// ==============================
always @(negedge clk) begin
    fetch_data = imem[fetch_addr[9:2]];
    #1;
    // Address settles after the fetch word, data only answers a read
    dbus_rdata = dbus_req.read ? dmem[dbus_req.addr[7:0]] : '0;
end

always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
        if (!rst && dbus_req.wstrb[b]) begin
            dmem[dbus_req.addr[7:0]][8*b +: 8] <= dbus_req.wdata[8*b +: 8];
        end
    end
end

// ==============================
// Helpers
// ==============================
function automatic logic [31:0] lcg();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
endfunction

function automatic logic [31:0] fill(int i);
    logic [31:0] a;
    a = i;
    return ({a[7:0], a[7:0], a[7:0], a[7:0]} ^ 32'h8C4A_F015) + a;
endfunction

function automatic logic [31:0] lane_mask(logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv32i_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv32i_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32i_isa_pkg::OPC_JAL};
endfunction

// ALU rule order is add sub sll slt sltu xor srl sra or and
function automatic logic [31:0] alu_model(int op, logic [31:0] a, logic [31:0] b);
    case (op)
        1:       return a - b;
        2:       return a << b[4:0];
        3:       return {31'b0, $signed(a) < $signed(b)};
        4:       return {31'b0, a < b};
        5:       return a ^ b;
        6:       return a >> b[4:0];
        7:       return $signed(a) >>> b[4:0];
        8:       return a | b;
        9:       return a & b;
        default: return a + b;
    endcase
endfunction

function automatic logic [2:0] op_f3(int op);
    case (op)
        2:       return 3'd1;
        3:       return 3'd2;
        4:       return 3'd3;
        5:       return 3'd4;
        6, 7:    return 3'd5;
        8:       return 3'd6;
        9:       return 3'd7;
        default: return 3'd0;
    endcase
endfunction

// Branch order is beq bne blt bge bltu bgeu
function automatic logic branch_model(int br, logic [31:0] a, logic [31:0] b);
    case (br)
        0:       return a == b;
        1:       return a != b;
        2:       return $signed(a) < $signed(b);
        3:       return $signed(a) >= $signed(b);
        4:       return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;  // Carry for the sign-extended low part
    prog.push_back({hi[31:12], rd, rv32i_isa_pkg::OPC_LUI});
    prog.push_back(enc_i(v[11:0], rd, 3'd0, rd, rv32i_isa_pkg::OPC_OP_IMM));
endtask

task automatic store_reg(input logic [4:0] r);
    prog.push_back(enc_s(12'h100, r, rv32i_isa_pkg::F3_WORD));
endtask

task automatic expect_store(input logic [31:0] d, input logic [3:0] s);
    exp_data.push_back(d);
    exp_strb.push_back(s);
endtask

task automatic run_program(input string name, input logic [31:0] halt_word);
    int len;
    prog.push_back(halt_word);
    len = prog.size();
    cycle_limit += len + 20;
    for (int i = 0; i < 256; i++) begin
        imem[i] = (i < len) ? prog[i] : 32'h0;
        dmem[i] = fill(i);
    end
    @(negedge clk);
    rst_req <= 1'b1;
    @(negedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    cur_test = name;  // Core sits in reset here
    halt_pc  = 32'(4 * (len - 1));
    while (rst) @(negedge clk);
    while (!halted) @(negedge clk);
    repeat (10) @(negedge clk);
    if (exp_strb.size() != 0) begin
        store_errs++;
        $display("Test %s halted with %0d expected stores missing", name, exp_strb.size());
    end
    exp_data.delete();
    exp_strb.delete();
    prog.delete();
endtask

// ==============================
// Checks
// ==============================
always @(posedge clk) begin
    if (!rst && dbus_req.wstrb != 4'b0) begin
        if (exp_strb.size() == 0) begin
            store_errs++;
            $display("Test %s wrote memory unexpectedly at pc %h", cur_test, fetch_addr);
        end else begin
            e_d = exp_data.pop_front();
            e_s = exp_strb.pop_front();
            assert (dbus_req.wstrb == e_s && (dbus_req.wdata & lane_mask(e_s)) == e_d) else begin
                store_errs++;
                $display("FAILED %s: expected %h/%b, actual %h/%b", cur_test, e_d, e_s,
                         dbus_req.wdata & lane_mask(e_s), dbus_req.wstrb);
            end
        end
    end
end

always @(posedge clk) begin
    prev_rst <= rst;
    halt_due <= !rst && !halted && fetch_addr == halt_pc;
    if (prev_rst && !rst) begin
        assert (fetch_addr == core_bus_pkg::RESET_VECTOR && !halted && dbus_req.wstrb == 4'b0)
        else begin
            ctrl_errs++;
            $display("FAILED %s reset: expected pc %h, actual pc %h halted %b wstrb %b",
                     cur_test, core_bus_pkg::RESET_VECTOR, fetch_addr, halted,
                     dbus_req.wstrb);
        end
    end
    if (!rst && halt_due) begin
        assert (halted) else begin
            ctrl_errs++;
            $display("FAILED %s halt: expected halted 1, actual %b", cur_test, halted);
        end
    end
    if (!rst && halted) begin
        assert (fetch_addr == halt_pc && dbus_req.wstrb == 4'b0 && !dbus_req.read) else begin
            ctrl_errs++;
            $display("FAILED %s halt: expected pc %h, actual pc %h wstrb %b read %b",
                     cur_test, halt_pc, fetch_addr, dbus_req.wstrb, dbus_req.read);
        end
    end
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
        $display("Run stopped after %0d cycles, a program never halted", cycles);
        $display("TEST FAIL");
        $finish;
    end
end

// ==============================
// Programs
// ==============================
initial begin
    logic [31:0] a, b, bv, w, p;
    logic [31:0] pa [0:3];
    logic [31:0] pb [0:3];
    rst_req = 1'b0;
    fetch_data = '0;
    dbus_rdata = '0;
    seed = 32'd86;
    cycles = 0;
    cycle_limit = 200;
    store_errs = 0;
    ctrl_errs = 0;
    halt_pc = '1;
    cur_test = "reset";

    for (int n = 0; n < 40; n++) begin
        a = lcg();
        b = lcg();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int op = 0; op < 10; op++) begin
            prog.push_back({(op == 1 || op == 7) ? rv32i_isa_pkg::F7_ALT : 7'b0, 5'd2, 5'd1,
                            op_f3(op), 5'd3, rv32i_isa_pkg::OPC_OP});
            store_reg(5'd3);
            expect_store(alu_model(op, a, b), 4'hF);
            if (op != 1) begin
                bv = (op == 2 || op == 6 || op == 7) ? {27'b0, b[4:0]} : {{20{b[11]}}, b[11:0]};
                if (op == 7) bv[10] = 1'b1;  // SRAI marker bit in the immediate
                prog.push_back(enc_i(bv[11:0], 5'd1, op_f3(op), 5'd3, rv32i_isa_pkg::OPC_OP_IMM));
                store_reg(5'd3);
                expect_store(alu_model(op, a, bv), 4'hF);
            end
        end
        run_program("alu", 32'h0000_0073);
    end

    w = fill(32);  // Word at byte address 0x80
    for (int k = 0; k < 4; k++) begin
        prog.push_back(enc_i(12'(12'h080 + k), 5'd0, 3'd0, 5'd3, rv32i_isa_pkg::OPC_LOAD));
        store_reg(5'd3);
        expect_store({{24{w[8*k+7]}}, w[8*k +: 8]}, 4'hF);
        prog.push_back(enc_i(12'(12'h080 + k), 5'd0, 3'd4, 5'd3, rv32i_isa_pkg::OPC_LOAD));
        store_reg(5'd3);
        expect_store({24'b0, w[8*k +: 8]}, 4'hF);
    end
    for (int k = 0; k < 4; k += 2) begin
        prog.push_back(enc_i(12'(12'h080 + k), 5'd0, 3'd1, 5'd3, rv32i_isa_pkg::OPC_LOAD));
        store_reg(5'd3);
        expect_store({{16{w[8*k+15]}}, w[8*k +: 16]}, 4'hF);
        prog.push_back(enc_i(12'(12'h080 + k), 5'd0, 3'd5, 5'd3, rv32i_isa_pkg::OPC_LOAD));
        store_reg(5'd3);
        expect_store({16'b0, w[8*k +: 16]}, 4'hF);
    end
    prog.push_back(enc_i(12'h080, 5'd0, 3'd2, 5'd3, rv32i_isa_pkg::OPC_LOAD));
    store_reg(5'd3);
    expect_store(w, 4'hF);
    load_const(5'd2, 32'hA1B2_C3D4);
    for (int k = 0; k < 4; k++) begin
        prog.push_back(enc_s(12'(12'h100 + k), 5'd2, rv32i_isa_pkg::F3_BYTE));
        expect_store(32'hD4 << (8 * k), 4'b0001 << k);
    end
    for (int k = 0; k < 4; k += 2) begin
        prog.push_back(enc_s(12'(12'h100 + k), 5'd2, rv32i_isa_pkg::F3_HALF));
        expect_store(32'hC3D4 << (8 * k), 4'b0011 << k);
    end
    run_program("load_store", 32'h0000_0073);

    pa = '{32'd5, 32'd5, 32'hFFFF_FFFD, 32'd2};
    pb = '{32'd5, 32'd7, 32'd2, 32'hFFFF_FFFD};
    load_const(5'd4, 32'd1);
    load_const(5'd5, 32'd2);
    for (int br = 0; br < 6; br++) begin
        for (int i = 0; i < 4; i++) begin
            load_const(5'd1, pa[i]);
            load_const(5'd2, pb[i]);
            prog.push_back(enc_b(13'd8, (br < 2) ? 3'(br) : 3'(br + 2)));
            store_reg(5'd4);  // Only on the fall-through path
            store_reg(5'd5);
            if (!branch_model(br, pa[i], pb[i])) expect_store(32'd1, 4'hF);
            expect_store(32'd2, 4'hF);
        end
    end
    p = 32'(4 * prog.size());
    prog.push_back(enc_j(21'd8, 5'd6));
    store_reg(5'd4);
    store_reg(5'd6);
    expect_store(p + 32'd4, 4'hF);
    p = 32'(4 * prog.size());
    prog.push_back(enc_i(12'(p + 32'd12), 5'd0, 3'd0, 5'd7, rv32i_isa_pkg::OPC_OP_IMM));
    prog.push_back(enc_i(12'd1, 5'd7, 3'd0, 5'd8, rv32i_isa_pkg::OPC_JALR));  // Bit 0 dropped
    store_reg(5'd4);
    store_reg(5'd8);
    expect_store(p + 32'd8, 4'hF);
    p = 32'(4 * prog.size());
    prog.push_back({20'h12345, 5'd9, rv32i_isa_pkg::OPC_AUIPC});
    store_reg(5'd9);
    expect_store(p + 32'h1234_5000, 4'hF);
    run_program("control_flow", 32'h0000_0073);

    for (int i = 0; i < 3; i++) begin
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd1, rv32i_isa_pkg::OPC_OP_IMM));
        store_reg(5'd1);
        expect_store(32'd1, 4'hF);
        case (i)
            0:       run_program("halt_ecall", 32'h0000_0073);
            1:       run_program("halt_ebreak", 32'h0010_0073);
            default: run_program("halt_illegal", 32'hFFFF_FFFF);
        endcase
    end

    $display("Store errors %0d, control errors %0d", store_errs, ctrl_errs);
    if (store_errs + ctrl_errs == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

//--- list.f
logic/rv32i_isa_pkg.sv
logic/core_bus_pkg.sv
logic/pc_unit.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/rv32i_core.sv
test/tb_clock_gen.sv
test/rv32i_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rv32i_core_tb \
    -o sim_rv32i > build.log 2>&1 \
    && ./obj_dir/sim_rv32i > sim.log 2>&1 \
    ; grep -q "^TEST PASS$" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
